// ==== compile.f ====
+incdir+bench
rtl/mem_hub_pkg.sv
rtl/mem_req_if.sv
rtl/mem_client_port.sv
rtl/sdram_arbiter.sv
rtl/word_store.sv
rtl/mem_hub_top.sv
bench/tb_mem_hub.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the memory hub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_mem_hub \
	-Mdir obj_dir -o tb_mem_hub > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "Verilator build failed, see build.log"
	exit 1
fi

./obj_dir/tb_mem_hub > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "TB FAILED" sim.log; then
	echo "Simulation reported failure"
	exit 1
fi

if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

exit 0

// ==== bench/tb_mem_hub_checks.svh ====
// Memory hub testbench reference memory model, expected byte function and compare tasks
`ifndef TB_MEM_HUB_CHECKS_SVH
`define TB_MEM_HUB_CHECKS_SVH

// ========================================
// Reference model
// ========================================

data8_t ref_mem [2 ** BYTE_ADDR_W];  // Byte view of the word store

// Expected byte for a client byte address
function automatic data8_t ref_byte(input byte_addr_t a);
	return ref_mem[a];
endfunction

// ========================================
// Failure and compare tasks
// ========================================

task automatic fail_stop(input string what);
	$display("%s", what);
	$display("TB FAILED");
	$fatal(1, "stopped at first error");
endtask

task automatic check_byte(input string name, input data8_t got, input data8_t exp);
	if (got !== exp)
		fail_stop($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

task automatic check_ready(input string name, input logic got, input logic exp);
	if (got !== exp)
		fail_stop($sformatf("** Error: %s got 0x%h expected 0x%h", name, got, exp));
endtask

`endif

// ==== bench/tb_mem_hub.sv ====
// Memory hub testbench driving byte clients and checking reads against a reference model
`default_nettype none

module tb_mem_hub
	import mem_hub_pkg::*;
();

	localparam int NUM_CLIENTS = 4;
	localparam int STIM_DELAY  = 1;
	localparam int WAIT_LIMIT  = NUM_CLIENTS * (ACCESS_CYCLES + 2);
	localparam int RAND_OPS    = 60;

	logic       clk_sys;
	logic       rst_n;
	byte_addr_t client_addr  [NUM_CLIENTS];
	data8_t     client_wdata [NUM_CLIENTS];
	logic       client_rd    [NUM_CLIENTS];
	logic       client_wr    [NUM_CLIENTS];
	data8_t     client_rdata [NUM_CLIENTS];
	logic       client_ready [NUM_CLIENTS];

	// Read results handed to the comparing process
	logic       check_req [NUM_CLIENTS];
	data8_t     exp_byte  [NUM_CLIENTS];
	int         seed = 32'h69dc7340;

	`include "tb_mem_hub_checks.svh"

	mem_hub_top #(
		.NUM_CLIENTS (NUM_CLIENTS)
	) mem_hub_top_inst (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.client_addr  (client_addr),
		.client_wdata (client_wdata),
		.client_rd    (client_rd),
		.client_wr    (client_wr),
		.client_rdata (client_rdata),
		.client_ready (client_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ========================================
	// Client access tasks
	// ========================================

	// Returns one stimulus delay after the edge where ready is high
	task automatic wait_ready(input int c);
		int cnt;
		cnt = 0;
		@(posedge clk_sys);
		#STIM_DELAY;
		while (!client_ready[c]) begin
			if (cnt >= WAIT_LIMIT)
				fail_stop($sformatf("Timeout: client %0d stalled waiting for ready", c));
			@(posedge clk_sys);
			#STIM_DELAY;
			cnt++;
		end
	endtask

	task automatic post_check(input int c, input byte_addr_t a);
		int cnt;
		cnt = 0;
		exp_byte[c]  = ref_byte(a);
		check_req[c] = 1'b1;
		while (check_req[c]) begin
			if (cnt >= WAIT_LIMIT)
				fail_stop($sformatf("Timeout: read of client %0d was never compared", c));
			@(posedge clk_sys);
			#STIM_DELAY;
			cnt++;
		end
	endtask

	task automatic do_write(input int c, input byte_addr_t a, input data8_t d);
		client_addr[c]  = a;
		client_wdata[c] = d;
		client_rd[c]    = 1'b0;
		client_wr[c]    = 1'b1;
		ref_mem[a]      = d;
		wait_ready(c);
		client_wr[c] = 1'b0;
		@(posedge clk_sys);  // Strobe low seen before the next write
		#STIM_DELAY;
	endtask

	task automatic do_read(input int c, input byte_addr_t a);
		client_addr[c] = a;
		client_wr[c]   = 1'b0;
		client_rd[c]   = 1'b1;
		wait_ready(c);
		post_check(c, a);
	endtask

	// Read served from the held word, ready never drops
	task automatic read_held(input int c, input byte_addr_t a, input int cycles);
		client_addr[c] = a;
		client_rd[c]   = 1'b1;
		for (int n = 0; n < cycles; n++) begin
			@(posedge clk_sys);
			check_ready($sformatf("client_ready[%0d]", c), client_ready[c], 1'b1);
			#STIM_DELAY;
		end
		post_check(c, a);
	endtask

	task automatic random_client(input int c);
		byte_addr_t written[$];
		byte_addr_t a;
		int         r;
		for (int n = 0; n < RAND_OPS; n++) begin
			r = $random(seed);
			if (written.size() == 0 || r[0]) begin
				a = {2'(c), 11'($random(seed))};  // Region by top two bits
				written.push_back(a);
				do_write(c, a, 8'($random(seed)));
			end else begin
				r = $unsigned($random(seed)) % written.size();
				do_read(c, written[r]);
			end
		end
		client_rd[c] = 1'b0;
	endtask

	// ========================================
	// Comparing process
	// ========================================

	initial begin
		forever begin
			@(posedge clk_sys);
			for (int i = 0; i < NUM_CLIENTS; i++) begin
				if (check_req[i] && client_ready[i]) begin
					check_byte($sformatf("client_rdata[%0d]", i), client_rdata[i], exp_byte[i]);
					check_req[i] = 1'b0;
				end
			end
		end
	end

	// ========================================
	// Main sequence
	// ========================================

	initial begin
		rst_n = 1'b0;
		for (int i = 0; i < NUM_CLIENTS; i++) begin
			client_addr[i]  = '0;
			client_wdata[i] = '0;
			client_rd[i]    = 1'b0;
			client_wr[i]    = 1'b0;
			check_req[i]    = 1'b0;
			exp_byte[i]     = '0;
		end
		repeat (10) @(posedge clk_sys);
		#STIM_DELAY rst_n = 1'b1;
		@(posedge clk_sys);
		#STIM_DELAY;

		for (int i = 0; i < NUM_CLIENTS; i++)
			check_ready($sformatf("client_ready[%0d]", i), client_ready[i], 1'b1);

		do_write(0, 13'h0024, 8'h5a);  // Single write and read back
		do_read(0, 13'h0024);

		do_write(1, 13'h0810, 8'h3c);  // Both bytes of one word
		do_write(1, 13'h0811, 8'hc3);
		do_read(1, 13'h0810);
		read_held(1, 13'h0811, 4);

		do_write(2, 13'h1047, 8'ha5);
		do_read(2, 13'h1047);
		repeat (3) read_held(2, 13'h1047, 3);  // Repeated read of one address
		client_rd[1] = 1'b0;
		client_rd[2] = 1'b0;

		for (int c = 0; c < NUM_CLIENTS; c++) begin
			automatic int cc = c;
			fork
				random_client(cc);
			join_none
		end
		wait fork;

		$display("TB PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== rtl/mem_hub_top.sv ====
// Memory hub top level joining byte clients to one word store through an arbiter
`default_nettype none

module mem_hub_top
	import mem_hub_pkg::*;
#(
	parameter int NUM_CLIENTS = 4
) (
	input  logic       clk_sys,
	input  logic       rst_n,

	input  byte_addr_t client_addr  [NUM_CLIENTS],
	input  data8_t     client_wdata [NUM_CLIENTS],
	input  logic       client_rd    [NUM_CLIENTS],
	input  logic       client_wr    [NUM_CLIENTS],
	output data8_t     client_rdata [NUM_CLIENTS],
	output logic       client_ready [NUM_CLIENTS]
);

	// Store side
	logic       mem_en;
	logic       mem_we;
	word_addr_t mem_addr;
	lane_t      mem_lanes;
	data16_t    mem_wdata;
	data16_t    mem_rdata;

	mem_req_if chan_if [NUM_CLIENTS] ();

	// ========================================
	// Client channels
	// ========================================

	for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_client
		mem_client_port mem_client_port_inst (
			.clk_sys (clk_sys),
			.rst_n   (rst_n),
			.addr    (client_addr[i]),
			.wdata   (client_wdata[i]),
			.rd      (client_rd[i]),
			.wr      (client_wr[i]),
			.rdata   (client_rdata[i]),
			.ready   (client_ready[i]),
			.bus     (chan_if[i])
		);
	end

	// ========================================
	// Arbiter and store
	// ========================================

	sdram_arbiter #(
		.NUM_CLIENTS (NUM_CLIENTS)
	) sdram_arbiter_inst (
		.clk_sys   (clk_sys),
		.rst_n     (rst_n),
		.chan      (chan_if),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_lanes (mem_lanes),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	word_store word_store_inst (
		.clk_sys (clk_sys),
		.en      (mem_en),
		.we      (mem_we),
		.addr    (mem_addr),
		.lanes   (mem_lanes),
		.wdata   (mem_wdata),
		.rdata   (mem_rdata)
	);

endmodule

`default_nettype wire

// ==== rtl/word_store.sv ====
// Word memory with byte-lane writes and registered read, in place of the SDRAM
`default_nettype none

module word_store
	import mem_hub_pkg::*;
(
	input  logic       clk_sys,

	input  logic       en,
	input  logic       we,
	input  word_addr_t addr,
	input  lane_t      lanes,
	input  data16_t    wdata,
	output data16_t    rdata
);

	localparam int DEPTH = 2 ** WORD_ADDR_W;

	data16_t mem [DEPTH];

	// ========================================
	// Access port
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (en) begin
			if (we) begin
				if (lanes[0])
					mem[addr][7:0] <= wdata[7:0];
				if (lanes[1])
					mem[addr][15:8] <= wdata[15:8];
			end

			// Old contents on a write cycle
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sdram_arbiter.sv ====
// Round-robin arbiter serving toggle requests against the word store
`default_nettype none

module sdram_arbiter
	import mem_hub_pkg::*;
#(
	parameter int NUM_CLIENTS = 4
) (
	input  logic       clk_sys,
	input  logic       rst_n,

	mem_req_if.arbiter chan [NUM_CLIENTS],

	output logic       mem_en,
	output logic       mem_we,
	output word_addr_t mem_addr,
	output lane_t      mem_lanes,
	output data16_t    mem_wdata,
	input  data16_t    mem_rdata
);

	localparam int IDX_W = (NUM_CLIENTS > 1) ? $clog2(NUM_CLIENTS) : 1;
	localparam int CNT_W = (ACCESS_CYCLES > 1) ? $clog2(ACCESS_CYCLES) : 1;

	logic [NUM_CLIENTS-1:0] req_vec;
	logic [NUM_CLIENTS-1:0] req_seen;   // Last seen req per channel
	logic [NUM_CLIENTS-1:0] pending;
	logic [NUM_CLIENTS-1:0] ack_q;
	logic [NUM_CLIENTS-1:0] clr_mask;   // Channel finishing this cycle

	logic       we_vec    [NUM_CLIENTS];
	word_addr_t addr_vec  [NUM_CLIENTS];
	lane_t      lanes_vec [NUM_CLIENTS];
	data16_t    wdata_vec [NUM_CLIENTS];

	data16_t    rdata_q;
	logic       busy;
	logic       done;
	logic       found;
	logic [IDX_W-1:0] grant;            // Also the round-robin pointer
	logic [IDX_W-1:0] pick;
	logic [CNT_W-1:0] cnt;

	// ========================================
	// Channel flattening
	// ========================================

	for (genvar i = 0; i < NUM_CLIENTS; i++) begin : g_chan
		assign req_vec[i]   = chan[i].req;
		assign we_vec[i]    = chan[i].we;
		assign addr_vec[i]  = chan[i].addr;
		assign lanes_vec[i] = chan[i].lanes;
		assign wdata_vec[i] = chan[i].wdata;

		assign chan[i].ack   = ack_q[i];
		assign chan[i].rdata = rdata_q;  // Only the acked channel samples it
	end

	// ========================================
	// Round-robin pick
	// ========================================

	// Nearest pending channel after the last grant wins
	always_comb begin
		int idx;
		pick  = grant;
		found = 1'b0;
		for (int k = NUM_CLIENTS; k >= 1; k--) begin
			idx = (int'(grant) + k) % NUM_CLIENTS;
			if (pending[idx]) begin
				pick  = IDX_W'(idx);
				found = 1'b1;
			end
		end
	end

	assign done     = busy && (cnt == CNT_W'(ACCESS_CYCLES - 1));
	assign clr_mask = done ? (NUM_CLIENTS'(1) << grant) : '0;

	// ========================================
	// Control
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req_seen <= '0;
			pending  <= '0;
			ack_q    <= '0;
			busy     <= 1'b0;
			grant    <= IDX_W'(NUM_CLIENTS - 1);  // First search starts at 0
			cnt      <= '0;
		end else begin
			req_seen <= req_vec;
			pending  <= (pending | (req_vec ^ req_seen)) & ~clr_mask;
			ack_q    <= ack_q ^ clr_mask;

			if (done) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt + 1'b1;
			end else if (found) begin
				busy  <= 1'b1;
				grant <= pick;
				cnt   <= '0;
			end
		end
	end

	// Read word returned together with the ack toggle
	always_ff @(posedge clk_sys) begin
		if (done)
			rdata_q <= mem_rdata;
	end

	// Store access in the first granted cycle
	assign mem_en    = busy && (cnt == '0);
	assign mem_we    = mem_en && we_vec[grant];
	assign mem_addr  = addr_vec[grant];
	assign mem_lanes = mem_we ? lanes_vec[grant] : '0;
	assign mem_wdata = wdata_vec[grant];

endmodule

`default_nettype wire

// ==== rtl/mem_client_port.sv ====
// Client channel turning byte accesses into toggle requests, with held word read-back
`default_nettype none

module mem_client_port
	import mem_hub_pkg::*;
(
	input  logic       clk_sys,
	input  logic       rst_n,

	input  byte_addr_t addr,
	input  data8_t     wdata,
	input  logic       rd,
	input  logic       wr,
	output data8_t     rdata,
	output logic       ready,

	mem_req_if.client  bus
);

	// ========================================
	// State
	// ========================================

	logic       req_q;      // Request toggle
	logic       ack_q;      // Last seen ack toggle
	logic       wr_q;       // Previous write strobe
	logic       stale;      // Held word no longer matches memory
	data16_t    held_word;

	word_addr_t req_addr;   // Word of the last request
	data16_t    req_wdata;
	lane_t      req_lanes;
	logic       req_we;

	word_addr_t word_addr;
	logic       idle;
	logic       wr_event;
	logic       rd_event;

	assign word_addr = addr[BYTE_ADDR_W-1:1];
	assign idle      = (req_q == ack_q);

	// Write on strobe rising edge only
	assign wr_event = idle && wr && !wr_q;

	// Read only when the held word cannot serve it
	assign rd_event = idle && rd && !wr_event && (stale || (word_addr != req_addr));

	// ========================================
	// Handshake and held word
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (!rst_n) begin
			req_q     <= 1'b0;
			ack_q     <= 1'b0;
			wr_q      <= 1'b0;
			stale     <= 1'b1;
			held_word <= '0;
		end else begin
			ack_q <= bus.ack;

			// Strobe edges seen only between requests
			if (idle)
				wr_q <= wr;

			if (wr_event || rd_event)
				req_q <= ~req_q;

			// A write leaves the held word out of date
			if (wr_event)
				stale <= 1'b1;
			else if (rd_event)
				stale <= 1'b0;

			if ((bus.ack != ack_q) && !req_we)
				held_word <= bus.rdata;  // Read done
		end
	end

	// Request payload, captured with the toggle
	always_ff @(posedge clk_sys) begin
		if (wr_event || rd_event) begin
			req_addr  <= word_addr;
			req_wdata <= {wdata, wdata};
			req_we    <= wr_event;
			if (wr_event)
				req_lanes <= addr[0] ? 2'b10 : 2'b01;
			else
				req_lanes <= 2'b00;
		end
	end

	assign bus.req   = req_q;
	assign bus.addr  = req_addr;
	assign bus.wdata = req_wdata;
	assign bus.lanes = req_lanes;
	assign bus.we    = req_we;

	// Byte select from the held word
	assign rdata = addr[0] ? held_word[15:8] : held_word[7:0];
	assign ready = idle;

endmodule

`default_nettype wire

// ==== rtl/mem_req_if.sv ====
// Toggle request/acknowledge channel from one client port to the arbiter
`default_nettype none

interface mem_req_if
	import mem_hub_pkg::*;
();

	// Request side, changes only together with a req toggle
	logic       req;    // Toggles once per new access
	word_addr_t addr;
	data16_t    wdata;  // Client byte copied to both lanes
	lane_t      lanes;
	logic       we;

	// Acknowledge side
	logic       ack;    // Toggles once per served req toggle
	data16_t    rdata;  // Valid in the cycle ack toggles

	modport client (
		output req,
		output addr,
		output wdata,
		output lanes,
		output we,
		input  ack,
		input  rdata
	);

	modport arbiter (
		input  req,
		input  addr,
		input  wdata,
		input  lanes,
		input  we,
		output ack,
		output rdata
	);

endinterface

`default_nettype wire

// ==== rtl/mem_hub_pkg.sv ====
// Memory hub shared widths, address and data types and arbiter timing
`default_nettype none

package mem_hub_pkg;

	// ========================================
	// Address widths
	// ========================================

	// Client byte address, 4096 words behind it
	localparam int BYTE_ADDR_W = 13;

	// Word address drops the byte select bit
	localparam int WORD_ADDR_W = BYTE_ADDR_W - 1;

	// ========================================
	// Payload types
	// ========================================

	typedef logic [BYTE_ADDR_W-1:0] byte_addr_t;
	typedef logic [WORD_ADDR_W-1:0] word_addr_t;

	typedef logic [7:0]  data8_t;   // One client byte
	typedef logic [15:0] data16_t;  // One memory word

	// Byte write enables, bit 0 is the low byte
	typedef logic [1:0] lane_t;

	// ========================================
	// Arbiter timing
	// ========================================

	// Cycles one granted access is held before its ack toggles
	localparam int ACCESS_CYCLES = 4;

endpackage

`default_nettype wire
